// ==== Bender.yml ====
package:
  name: axi_mem_lite

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - axi_mem_lite_pkg.sv
      - axi_mem_lite_connect.sv
      - axi_mem_lite_ctrl.sv
      - axi_mem_lite_array.sv
      - axi_mem_lite_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - axi_mem_lite_tb.sv

// ==== axi_mem_lite_array.sv ====
// Word memory behind the controller, registered read and byte-lane write under strobe
`timescale 1ns/1ps
`include "axi_mem_lite_config.svh"

module axi_mem_lite_array
(
    input  logic                             clk,

    // Read port, data shows up one cycle after rd_en
    input  logic                             rd_en,
    input  logic [`AXI_MEM_WORDS_LOG2-1:0]   rd_index,
    output logic [`AXI_MEM_DATA_WIDTH-1:0]   rd_data,

    // Write port, each strobe bit enables one byte lane
    input  logic                             wr_en,
    input  logic [`AXI_MEM_WORDS_LOG2-1:0]   wr_index,
    input  logic [`AXI_MEM_DATA_WIDTH-1:0]   wr_data,
    input  logic [`AXI_MEM_STRB_WIDTH-1:0]   wr_strb
);

    // Storage, contents start undefined
    logic [`AXI_MEM_DATA_WIDTH-1:0] mem [`AXI_MEM_WORDS];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int lane = 0; lane < `AXI_MEM_STRB_WIDTH; lane++)
            begin
                // Lanes with a clear strobe keep their old byte
                if (wr_strb[lane])
                begin
                    mem[wr_index][lane*8 +: 8] <= wr_data[lane*8 +: 8];
                end
            end
        end
    end

    // A read colliding with a write to the same word returns the old word
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_index];
        end
    end

endmodule

// ==== axi_mem_lite_config.svh ====
// Memory geometry macros for the AXI4-Lite endpoint, included by the package and each RTL file
`ifndef AXI_MEM_LITE_CONFIG_SVH
`define AXI_MEM_LITE_CONFIG_SVH

// Byte address width seen on the AXI4-Lite port
`define AXI_MEM_ADDR_WIDTH 16

// Data word width, one strobe bit per byte lane
`define AXI_MEM_DATA_WIDTH 32
`define AXI_MEM_STRB_WIDTH (`AXI_MEM_DATA_WIDTH / 8)

// Memory depth in words, 256 words for a log2 of 8
`define AXI_MEM_WORDS_LOG2 8
`define AXI_MEM_WORDS (1 << `AXI_MEM_WORDS_LOG2)

// Split of the byte address into region, word index and byte offset
`define AXI_MEM_OFFSET_BITS 2
`define AXI_MEM_REGION_BITS \
    (`AXI_MEM_ADDR_WIDTH - `AXI_MEM_WORDS_LOG2 - `AXI_MEM_OFFSET_BITS)

`endif

// ==== axi_mem_lite_connect.sv ====
// Registered AXI4-Lite joint with skid buffers on AW, W and AR that sits between host and controller
`timescale 1ns/1ps
`include "axi_mem_lite_config.svh"

module axi_mem_lite_connect
    import axi_mem_lite_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,

    // The joint acts as the slave on the host side
    input  logic                             s_awvalid,
    output logic                             s_awready,
    input  logic [`AXI_MEM_ADDR_WIDTH-1:0]   s_awaddr,
    input  logic                             s_wvalid,
    output logic                             s_wready,
    input  logic [`AXI_MEM_DATA_WIDTH-1:0]   s_wdata,
    input  logic [`AXI_MEM_STRB_WIDTH-1:0]   s_wstrb,
    output logic                             s_bvalid,
    input  logic                             s_bready,
    output axi_resp_t                        s_bresp,
    input  logic                             s_arvalid,
    output logic                             s_arready,
    input  logic [`AXI_MEM_ADDR_WIDTH-1:0]   s_araddr,
    output logic                             s_rvalid,
    input  logic                             s_rready,
    output logic [`AXI_MEM_DATA_WIDTH-1:0]   s_rdata,
    output axi_resp_t                        s_rresp,

    // The joint acts as the master toward the controller
    output logic                             m_awvalid,
    input  logic                             m_awready,
    output logic [`AXI_MEM_ADDR_WIDTH-1:0]   m_awaddr,
    output logic                             m_wvalid,
    input  logic                             m_wready,
    output logic [`AXI_MEM_DATA_WIDTH-1:0]   m_wdata,
    output logic [`AXI_MEM_STRB_WIDTH-1:0]   m_wstrb,
    input  logic                             m_bvalid,
    output logic                             m_bready,
    input  axi_resp_t                        m_bresp,
    output logic                             m_arvalid,
    input  logic                             m_arready,
    output logic [`AXI_MEM_ADDR_WIDTH-1:0]   m_araddr,
    input  logic                             m_rvalid,
    output logic                             m_rready,
    input  logic [`AXI_MEM_DATA_WIDTH-1:0]   m_rdata,
    input  axi_resp_t                        m_rresp
);

    // Channel numbering inside the shared skid buffer generate loop
    localparam int CH_AW = 0;
    localparam int CH_W = 1;
    localparam int CH_AR = 2;
    localparam int PAYLOAD_W = `AXI_MEM_DATA_WIDTH + `AXI_MEM_STRB_WIDTH;

    logic                 in_valid [3];
    logic                 in_ready [3];
    logic [PAYLOAD_W-1:0] in_payload [3];
    logic                 out_valid [3];
    logic                 out_ready [3];
    logic [PAYLOAD_W-1:0] out_payload [3];

    // Gather the three request channels into a common form
    assign in_valid[CH_AW] = s_awvalid;
    assign in_valid[CH_W] = s_wvalid;
    assign in_valid[CH_AR] = s_arvalid;
    assign in_payload[CH_AW] = PAYLOAD_W'(s_awaddr);
    assign in_payload[CH_W] = {s_wstrb, s_wdata};
    assign in_payload[CH_AR] = PAYLOAD_W'(s_araddr);
    assign out_ready[CH_AW] = m_awready;
    assign out_ready[CH_W] = m_wready;
    assign out_ready[CH_AR] = m_arready;

    for (genvar ch = 0; ch < 3; ch++)
    begin : g_skid
        // Address channels keep only the address bits while W keeps strobe and data
        localparam int W = (ch == CH_W) ? PAYLOAD_W : `AXI_MEM_ADDR_WIDTH;

        logic [W-1:0] entry [2];
        logic         wr_ptr;
        logic         rd_ptr;
        logic [1:0]   count;
        logic [1:0]   count_next;
        logic         ready_q;
        logic         push;
        logic         pop;

        assign push = in_valid[ch] && ready_q;
        assign pop = out_valid[ch] && out_ready[ch];
        assign count_next = count + 2'(push) - 2'(pop);

        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                count <= '0;
                wr_ptr <= 1'b0;
                rd_ptr <= 1'b0;
                ready_q <= 1'b0;
            end
            else
            begin
                count <= count_next;
                wr_ptr <= wr_ptr ^ push;
                rd_ptr <= rd_ptr ^ pop;
                // Ready follows occupancy alone so the target ready never reaches the host
                ready_q <= (count_next != 2'd2);
            end
        end

        // Each accepted transfer stores its payload in the entry at the write pointer
        always_ff @(posedge clk)
        begin
            if (push)
            begin
                entry[wr_ptr] <= in_payload[ch][W-1:0];
            end
        end

        assign in_ready[ch] = ready_q;
        assign out_valid[ch] = (count != 2'd0);
        assign out_payload[ch] = PAYLOAD_W'(entry[rd_ptr]);
    end

    assign s_awready = in_ready[CH_AW];
    assign s_wready = in_ready[CH_W];
    assign s_arready = in_ready[CH_AR];

    assign m_awvalid = out_valid[CH_AW];
    assign m_awaddr = out_payload[CH_AW][`AXI_MEM_ADDR_WIDTH-1:0];
    assign m_wvalid = out_valid[CH_W];
    assign {m_wstrb, m_wdata} = out_payload[CH_W];
    assign m_arvalid = out_valid[CH_AR];
    assign m_araddr = out_payload[CH_AR][`AXI_MEM_ADDR_WIDTH-1:0];

    // Responses already come from registers in the controller and pass straight through
    assign s_bvalid = m_bvalid;
    assign s_bresp = m_bresp;
    assign m_bready = s_bready;
    assign s_rvalid = m_rvalid;
    assign s_rdata = m_rdata;
    assign s_rresp = m_rresp;
    assign m_rready = s_rready;

endmodule

// ==== axi_mem_lite_ctrl.sv ====
// Controller FSM serving one AXI4-Lite read or write at a time from the word memory
`timescale 1ns/1ps
`include "axi_mem_lite_config.svh"

module axi_mem_lite_ctrl
    import axi_mem_lite_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,

    // Request and response channels from the joint
    input  logic                             m_awvalid,
    output logic                             m_awready,
    input  logic [`AXI_MEM_ADDR_WIDTH-1:0]   m_awaddr,
    input  logic                             m_wvalid,
    output logic                             m_wready,
    input  logic [`AXI_MEM_DATA_WIDTH-1:0]   m_wdata,
    input  logic [`AXI_MEM_STRB_WIDTH-1:0]   m_wstrb,
    output logic                             m_bvalid,
    input  logic                             m_bready,
    output axi_resp_t                        m_bresp,
    input  logic                             m_arvalid,
    output logic                             m_arready,
    input  logic [`AXI_MEM_ADDR_WIDTH-1:0]   m_araddr,
    output logic                             m_rvalid,
    input  logic                             m_rready,
    output logic [`AXI_MEM_DATA_WIDTH-1:0]   m_rdata,
    output axi_resp_t                        m_rresp,

    // Memory array ports
    output logic                             rd_en,
    output logic [`AXI_MEM_WORDS_LOG2-1:0]   rd_index,
    input  logic [`AXI_MEM_DATA_WIDTH-1:0]   rd_data,
    output logic                             wr_en,
    output logic [`AXI_MEM_WORDS_LOG2-1:0]   wr_index,
    output logic [`AXI_MEM_DATA_WIDTH-1:0]   wr_data,
    output logic [`AXI_MEM_STRB_WIDTH-1:0]   wr_strb
);

    // FSM state encoding
    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] READ_WAIT = 2'd1;
    localparam logic [1:0] READ_RESP = 2'd2;
    localparam logic [1:0] WRITE_RESP = 2'd3;

    logic [1:0]                       state;
    logic                             prefer_read;
    mem_addr_u                        aw_addr;
    mem_addr_u                        ar_addr;
    logic                             aw_decerr;
    logic                             ar_decerr;
    logic                             wr_req;
    logic                             rd_req;
    logic                             take_write;
    logic                             take_read;
    axi_resp_t                        bresp_q;
    axi_resp_t                        rresp_q;
    logic [`AXI_MEM_DATA_WIDTH-1:0]   rdata_q;

    // Decode both request addresses through the shared union
    assign aw_addr.raw = m_awaddr;
    assign ar_addr.raw = m_araddr;
    assign aw_decerr = (aw_addr.f.region != '0);
    assign ar_decerr = (ar_addr.f.region != '0);

    // A write needs both its address and its data before it can be taken
    assign wr_req = m_awvalid && m_wvalid;
    assign rd_req = m_arvalid;

    always_comb
    begin
        take_write = 1'b0;
        take_read = 1'b0;
        if (state == IDLE)
        begin
            if (wr_req && rd_req)
            begin
                // The round-robin flag decides when both kinds are pending
                take_read = prefer_read;
                take_write = !prefer_read;
            end
            else
            begin
                take_write = wr_req;
                take_read = rd_req;
            end
        end
    end

    assign m_awready = take_write;
    assign m_wready = take_write;
    assign m_arready = take_read;

    // Out-of-range writes are dropped and out-of-range reads skip the array
    assign wr_en = take_write && !aw_decerr;
    assign wr_index = aw_addr.f.word_index;
    assign wr_data = m_wdata;
    assign wr_strb = m_wstrb;
    assign rd_en = take_read && !ar_decerr;
    assign rd_index = ar_addr.f.word_index;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            prefer_read <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (take_write)
                    begin
                        state <= WRITE_RESP;
                        prefer_read <= 1'b1;
                    end
                    else if (take_read)
                    begin
                        state <= READ_WAIT;
                        prefer_read <= 1'b0;
                    end
                end
                // The array word arrives during this cycle
                READ_WAIT: state <= READ_RESP;
                READ_RESP:
                begin
                    if (m_rready)
                    begin
                        state <= IDLE;
                    end
                end
                WRITE_RESP:
                begin
                    if (m_bready)
                    begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Response payload stays stable while the host stalls
    always_ff @(posedge clk)
    begin
        if (take_write)
        begin
            bresp_q <= aw_decerr ? DECERR : OKAY;
        end
        if (take_read)
        begin
            rresp_q <= ar_decerr ? DECERR : OKAY;
        end
        if (state == READ_WAIT)
        begin
            // Decode errors return zero in place of the stale array output
            rdata_q <= (rresp_q == DECERR) ? '0 : rd_data;
        end
    end

    assign m_bvalid = (state == WRITE_RESP);
    assign m_bresp = bresp_q;
    assign m_rvalid = (state == READ_RESP);
    assign m_rdata = rdata_q;
    assign m_rresp = rresp_q;

endmodule

// ==== axi_mem_lite_pkg.sv ====
// Types shared by the endpoint RTL and its testbench, pulled in by a wildcard import
`include "axi_mem_lite_config.svh"

package axi_mem_lite_pkg;

    // AXI response codes, only the two this endpoint ever returns
    typedef enum logic [1:0]
    {
        OKAY   = 2'b00,
        DECERR = 2'b11
    } axi_resp_t;

    // Field view of a byte address
    // The region must be zero for the address to land inside the memory
    typedef struct packed
    {
        logic [`AXI_MEM_REGION_BITS-1:0] region;
        logic [`AXI_MEM_WORDS_LOG2-1:0]  word_index;
        logic [`AXI_MEM_OFFSET_BITS-1:0] byte_offset;
    } mem_addr_fields_t;

    // One address word read either as it arrives on the bus or split into fields
    typedef union packed
    {
        logic [`AXI_MEM_ADDR_WIDTH-1:0] raw;
        mem_addr_fields_t               f;
    } mem_addr_u;

endpackage

// ==== axi_mem_lite_tb.sv ====
// Self-checking testbench that drives the AXI4-Lite memory endpoint as the simulation top
`timescale 1ns/1ps
`include "axi_mem_lite_config.svh"

module axi_mem_lite_tb
    import axi_mem_lite_pkg::*;
();

    typedef logic [`AXI_MEM_DATA_WIDTH-1:0] data_t;
    typedef logic [`AXI_MEM_STRB_WIDTH-1:0] strb_t;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_OPS = 200;
    localparam int MAX_REGION = (1 << `AXI_MEM_REGION_BITS) - 1;

    logic                           clk;
    logic                           reset;
    logic                           s_awvalid;
    logic                           s_awready;
    logic [`AXI_MEM_ADDR_WIDTH-1:0] s_awaddr;
    logic                           s_wvalid;
    logic                           s_wready;
    data_t                          s_wdata;
    strb_t                          s_wstrb;
    logic                           s_bvalid;
    logic                           s_bready;
    axi_resp_t                      s_bresp;
    logic                           s_arvalid;
    logic                           s_arready;
    logic [`AXI_MEM_ADDR_WIDTH-1:0] s_araddr;
    logic                           s_rvalid;
    logic                           s_rready;
    data_t                          s_rdata;
    axi_resp_t                      s_rresp;

    // Reference memory holds entries only for the words written so far
    data_t     model_mem [int];

    // Expected responses wait in issue order in one queue per response channel
    axi_resp_t exp_bresp_q [$];
    axi_resp_t exp_rresp_q [$];
    data_t     exp_rdata_q [$];

    string     cur_test;
    int        pass_count;
    int        fail_count;
    int        test_pass_base;
    int        test_fail_base;

    // 0 keeps both response readies high, 1 toggles them at random, 2 holds bready low
    int        ready_mode;

    axi_mem_lite_top axi_mem_lite_top_inst
    (
        .clk       (clk),
        .reset     (reset),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_awaddr  (s_awaddr),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_bresp   (s_bresp),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_araddr  (s_araddr),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp)
    );

    always #20 clk = ~clk;

    // Response readies change on the falling edge like every other input
    always @(negedge clk)
    begin
        case (ready_mode)
            1:
            begin
                s_bready = $urandom % 2;
                s_rready = $urandom % 2;
            end
            2:
            begin
                s_bready = 1'b0;
                s_rready = 1'b1;
            end
            default:
            begin
                s_bready = 1'b1;
                s_rready = 1'b1;
            end
        endcase
    end

    // Builds a byte address from its three fields through the shared union
    function automatic mem_addr_u make_addr(input int region, input int index, input int offset);
        mem_addr_u a;
        a.f.region = region[`AXI_MEM_REGION_BITS-1:0];
        a.f.word_index = index[`AXI_MEM_WORDS_LOG2-1:0];
        a.f.byte_offset = offset[`AXI_MEM_OFFSET_BITS-1:0];
        return a;
    endfunction

    // Every byte of the initial contents depends on the word index
    function automatic data_t fill_word(input int index);
        return {index[7:0], ~index[7:0], index[7:0] ^ 8'h5a, index[7:0] + 8'h3c};
    endfunction

    // Returns the expected response of one access and applies a write to the model
    function automatic axi_resp_t model_access(input bit is_write, input mem_addr_u addr,
                                               input data_t wdata, input strb_t strb,
                                               output data_t rdata);
        data_t word;
        int    idx;
        rdata = '0;
        if (addr.f.region != '0)
        begin
            return DECERR;
        end
        idx = addr.f.word_index;
        word = model_mem.exists(idx) ? model_mem[idx] : '0;
        if (is_write)
        begin
            for (int lane = 0; lane < `AXI_MEM_STRB_WIDTH; lane++)
            begin
                if (strb[lane])
                begin
                    word[lane*8 +: 8] = wdata[lane*8 +: 8];
                end
            end
            model_mem[idx] = word;
        end
        else
        begin
            rdata = word;
        end
        return OKAY;
    endfunction

    task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
        if (exp !== act)
        begin
            $display("Error: test %s, response expected %s, actual %s",
                     name, exp.name(), act.name());
            fail_count++;
        end
        else
        begin
            pass_count++;
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act)
        begin
            $display("Error: test %s, read data expected %h, actual %h", name, exp, act);
            fail_count++;
        end
        else
        begin
            pass_count++;
        end
    endtask

    // Every completed B and R transfer is matched against its queue
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (s_bvalid && s_bready)
            begin
                if (exp_bresp_q.size() == 0)
                begin
                    $display("Test %s got a write response with no write outstanding", cur_test);
                    fail_count++;
                end
                else
                begin
                    check_resp(cur_test, exp_bresp_q.pop_front(), s_bresp);
                end
            end
            if (s_rvalid && s_rready)
            begin
                if (exp_rresp_q.size() == 0)
                begin
                    $display("Test %s got a read response with no read outstanding", cur_test);
                    fail_count++;
                end
                else
                begin
                    check_resp(cur_test, exp_rresp_q.pop_front(), s_rresp);
                    check_data(cur_test, exp_rdata_q.pop_front(), s_rdata);
                end
            end
        end
    end

    // Prints the closing counts and ends the run
    task automatic end_run();
        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Test %s timed out waiting for %s", cur_test, what);
        fail_count++;
        end_run();
    endtask

    // Issues AW and W together and returns once both have been accepted
    task automatic write_word(input mem_addr_u addr, input data_t data, input strb_t strb);
        data_t unused;
        bit    aw_done;
        bit    w_done;
        int    cycles;
        exp_bresp_q.push_back(model_access(1'b1, addr, data, strb, unused));
        @(negedge clk);
        s_awvalid = 1'b1;
        s_awaddr = addr.raw;
        s_wvalid = 1'b1;
        s_wdata = data;
        s_wstrb = strb;
        aw_done = 1'b0;
        w_done = 1'b0;
        cycles = 0;
        while (!(aw_done && w_done))
        begin
            @(posedge clk);
            aw_done |= s_awvalid && s_awready;
            w_done |= s_wvalid && s_wready;
            @(negedge clk);
            if (aw_done)
            begin
                s_awvalid = 1'b0;
            end
            if (w_done)
            begin
                s_wvalid = 1'b0;
            end
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
            begin
                report_timeout("the write request handshake");
            end
        end
    endtask

    task automatic read_word(input mem_addr_u addr);
        data_t exp_data;
        int    cycles;
        exp_rresp_q.push_back(model_access(1'b0, addr, '0, '0, exp_data));
        exp_rdata_q.push_back(exp_data);
        @(negedge clk);
        s_arvalid = 1'b1;
        s_araddr = addr.raw;
        cycles = 0;
        while (s_arvalid)
        begin
            @(posedge clk);
            if (s_arready)
            begin
                @(negedge clk);
                s_arvalid = 1'b0;
            end
            else
            begin
                @(negedge clk);
            end
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
            begin
                report_timeout("the read request handshake");
            end
        end
    endtask

    // Waits until every issued request has its response
    task automatic wait_responses();
        int cycles;
        cycles = 0;
        while (exp_bresp_q.size() != 0 || exp_rresp_q.size() != 0)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
            begin
                report_timeout("outstanding responses");
            end
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_pass_base = pass_count;
        test_fail_base = fail_count;
    endtask

    task automatic end_test();
        int errs;
        errs = fail_count - test_fail_base;
        $display("Test %s done: %0d checks, %0d errors",
                 cur_test, pass_count - test_pass_base + errs, errs);
    endtask

    task automatic run_random_mix();
        int    region;
        int    index;
        int    offset;
        data_t data;
        strb_t strb;
        bit    is_write;
        bit    last_write;
        last_write = 1'b0;
        for (int n = 0; n < RANDOM_OPS; n++)
        begin
            // About one access in four lands outside the memory
            region = (($urandom % 4) == 0) ? 1 + ($urandom % MAX_REGION) : 0;
            index = $urandom % `AXI_MEM_WORDS;
            offset = $urandom % 4;
            is_write = $urandom % 2;
            // Accesses of one kind queue up back to back until the kind changes
            if (is_write != last_write)
            begin
                wait_responses();
            end
            last_write = is_write;
            if (is_write)
            begin
                data = $urandom;
                strb = $urandom % 16;
                write_word(make_addr(region, index, offset), data, strb);
            end
            else
            begin
                read_word(make_addr(region, index, offset));
            end
        end
        wait_responses();
    endtask

    // Holding bready low must fill the skid buffers and drop both write readies
    task automatic wait_ready_drop();
        int cycles;
        cycles = 0;
        while (s_awready || s_wready)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
            begin
                report_timeout("the write readies to drop under back-pressure");
            end
        end
        pass_count++;
    endtask

    initial
    begin
        void'($urandom(1));
        clk = 1'b0;
        reset = 1'b1;
        s_awvalid = 1'b0;
        s_awaddr = '0;
        s_wvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_bready = 1'b1;
        s_arvalid = 1'b0;
        s_araddr = '0;
        s_rready = 1'b1;
        ready_mode = 0;
        pass_count = 0;
        fail_count = 0;
        cur_test = "reset";
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // Every word gets a known value before anything reads it
        start_test("fill");
        for (int i = 0; i < `AXI_MEM_WORDS; i++)
        begin
            write_word(make_addr(0, i, 0), fill_word(i), 4'hf);
        end
        wait_responses();
        end_test();

        start_test("full_word");
        write_word(make_addr(0, 17, 0), 32'h1234_5678, 4'hf);
        wait_responses();
        read_word(make_addr(0, 17, 0));
        wait_responses();
        end_test();

        start_test("partial_strobe");
        write_word(make_addr(0, 42, 0), 32'hcafe_f00d, 4'hf);
        write_word(make_addr(0, 42, 1), 32'h1122_3344, 4'b0101);
        write_word(make_addr(0, 42, 3), 32'h99aa_bbcc, 4'b1000);
        wait_responses();
        read_word(make_addr(0, 42, 0));
        wait_responses();
        end_test();

        start_test("decode_error");
        write_word(make_addr(5, 33, 0), 32'hdead_beef, 4'hf);
        wait_responses();
        read_word(make_addr(5, 33, 0));
        read_word(make_addr(0, 33, 0));
        wait_responses();
        end_test();

        start_test("random_mix");
        ready_mode = 1;
        run_random_mix();
        ready_mode = 0;
        end_test();

        start_test("bready_backpressure");
        ready_mode = 2;
        // One write parks in the controller and two fill the skid buffers
        for (int i = 0; i < 3; i++)
        begin
            write_word(make_addr(0, 200 + i, 0), 32'ha500_0000 | i, 4'hf);
        end
        wait_ready_drop();
        ready_mode = 0;
        for (int i = 3; i < 6; i++)
        begin
            write_word(make_addr(0, 200 + i, 0), 32'ha500_0000 | i, 4'hf);
        end
        wait_responses();
        for (int i = 0; i < 6; i++)
        begin
            read_word(make_addr(0, 200 + i, 0));
        end
        wait_responses();
        end_test();

        end_run();
    end

endmodule

// ==== axi_mem_lite_top.f ====
+incdir+.
axi_mem_lite_pkg.sv
axi_mem_lite_connect.sv
axi_mem_lite_ctrl.sv
axi_mem_lite_array.sv
axi_mem_lite_top.sv
axi_mem_lite_tb.sv

// ==== axi_mem_lite_top.sv ====
// Endpoint top level that carries the host AXI4-Lite port through the joint into the controller
`timescale 1ns/1ps
`include "axi_mem_lite_config.svh"

module axi_mem_lite_top
    import axi_mem_lite_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,

    // AXI4-Lite host port
    input  logic                             s_awvalid,
    output logic                             s_awready,
    input  logic [`AXI_MEM_ADDR_WIDTH-1:0]   s_awaddr,
    input  logic                             s_wvalid,
    output logic                             s_wready,
    input  logic [`AXI_MEM_DATA_WIDTH-1:0]   s_wdata,
    input  logic [`AXI_MEM_STRB_WIDTH-1:0]   s_wstrb,
    output logic                             s_bvalid,
    input  logic                             s_bready,
    output axi_resp_t                        s_bresp,
    input  logic                             s_arvalid,
    output logic                             s_arready,
    input  logic [`AXI_MEM_ADDR_WIDTH-1:0]   s_araddr,
    output logic                             s_rvalid,
    input  logic                             s_rready,
    output logic [`AXI_MEM_DATA_WIDTH-1:0]   s_rdata,
    output axi_resp_t                        s_rresp
);

    // Joint to controller channels
    logic                             m_awvalid;
    logic                             m_awready;
    logic [`AXI_MEM_ADDR_WIDTH-1:0]   m_awaddr;
    logic                             m_wvalid;
    logic                             m_wready;
    logic [`AXI_MEM_DATA_WIDTH-1:0]   m_wdata;
    logic [`AXI_MEM_STRB_WIDTH-1:0]   m_wstrb;
    logic                             m_bvalid;
    logic                             m_bready;
    axi_resp_t                        m_bresp;
    logic                             m_arvalid;
    logic                             m_arready;
    logic [`AXI_MEM_ADDR_WIDTH-1:0]   m_araddr;
    logic                             m_rvalid;
    logic                             m_rready;
    logic [`AXI_MEM_DATA_WIDTH-1:0]   m_rdata;
    axi_resp_t                        m_rresp;

    // Controller to memory array
    logic                             rd_en;
    logic [`AXI_MEM_WORDS_LOG2-1:0]   rd_index;
    logic [`AXI_MEM_DATA_WIDTH-1:0]   rd_data;
    logic                             wr_en;
    logic [`AXI_MEM_WORDS_LOG2-1:0]   wr_index;
    logic [`AXI_MEM_DATA_WIDTH-1:0]   wr_data;
    logic [`AXI_MEM_STRB_WIDTH-1:0]   wr_strb;

    // The joint and the controller meet on the same-named m_ channel signals
    axi_mem_lite_connect axi_mem_lite_connect_inst
    (
        .*
    );

    axi_mem_lite_ctrl axi_mem_lite_ctrl_inst
    (
        .*
    );

    axi_mem_lite_array axi_mem_lite_array_inst
    (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb)
    );

endmodule
